// File: source/mvdm_pkg.sv
// motion vector refinement definitions
`default_nettype none

package mvdm_pkg;

    // ==============================
    // sizes
    // ==============================
    localparam int IMG_DIM         = 16;
    localparam int IMG_PIXELS      = IMG_DIM * IMG_DIM;
    localparam int MAX_MV          = 6;
    localparam int NUM_POINTS      = 9;
    localparam int STEPS_PER_POINT = 16;
    localparam int GROUP           = 4;
    localparam int MV_BYTES        = 4;
    localparam int RESULT_BITS     = 28;

    // ==============================
    // data types
    // ==============================
    typedef logic        [7:0]  pixel_t;
    typedef logic        [3:0]  coord_t;
    typedef logic signed [8:0]  residual_t;
    typedef logic signed [10:0] coef_t;
    typedef logic signed [12:0] had_t;
    typedef logic        [23:0] satd_t;
    typedef logic        [3:0]  point_t;
    typedef logic        [3:0]  step_t;

    // start value of the running minimum
    localparam satd_t SATD_INIT = '1;

    typedef enum logic [2:0] {
        st_idle,
        st_load,
        st_mv,
        st_search,
        st_drain,
        st_output
    } ctrl_state_e;

endpackage

`default_nettype wire

// File: source/mvdm_ctrl.sv
// phase controller
`timescale 1ns/10ps
`default_nettype none

module mvdm_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  logic                  in_valid2,
    input  logic                  load_last,
    input  logic                  mv_last,
    input  logic                  search_last,
    input  logic                  search_done,
    input  logic                  out_last,
    output mvdm_pkg::ctrl_state_e state
);
    import mvdm_pkg::*;

    ctrl_state_e next_state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    // first byte of a phase is taken while still idle
    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (in_valid) begin
                    next_state = st_load;
                end else if (in_valid2) begin
                    next_state = st_mv;
                end
            end
            st_load:   if (load_last)   next_state = st_idle;
            st_mv:     if (mv_last)     next_state = st_search;
            st_search: if (search_last) next_state = st_drain;
            // wait for the last point to leave the pipeline
            st_drain:  if (search_done) next_state = st_output;
            st_output: if (out_last)    next_state = st_idle;
            default:   next_state = st_idle;
        endcase
    end

endmodule

`default_nettype wire

// File: source/search_counter.sv
// phase counters
`timescale 1ns/10ps
`default_nettype none

module search_counter (
    input  logic                  clk,
    input  logic                  rst_n,
    input  mvdm_pkg::ctrl_state_e state,
    input  logic                  in_valid,
    input  logic                  in_valid2,
    output logic [8:0]            load_addr,
    output logic [1:0]            mv_idx,
    output mvdm_pkg::step_t       step,
    output mvdm_pkg::point_t      point,
    output logic                  step_valid,
    output logic                  load_last,
    output logic                  mv_last,
    output logic                  search_last,
    output logic [4:0]            out_idx,
    output logic                  out_last
);
    import mvdm_pkg::*;

    assign step_valid  = (state == st_search);
    assign load_last   = in_valid && (load_addr == 9'(2 * IMG_PIXELS - 1));
    assign mv_last     = in_valid2 && (mv_idx == 2'(MV_BYTES - 1));
    assign search_last = step_valid && (step == step_t'(STEPS_PER_POINT - 1)) &&
                         (point == point_t'(NUM_POINTS - 1));
    assign out_last    = (state == st_output) && (out_idx == 5'(RESULT_BITS - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_addr <= '0;
            mv_idx    <= '0;
            step      <= '0;
            point     <= '0;
            out_idx   <= '0;
        end else begin
            // pixel and vector byte counts wrap at the end of their phase
            if (in_valid) begin
                load_addr <= load_addr + 9'd1;
            end else if (state != st_load) begin
                load_addr <= '0;
            end

            if (in_valid2) begin
                mv_idx <= mv_idx + 2'd1;
            end else if (state != st_mv) begin
                mv_idx <= '0;
            end

            // step inside point, 16 x 9
            if (step_valid && !search_last) begin
                step <= step + step_t'(1);
                if (step == step_t'(STEPS_PER_POINT - 1)) begin
                    point <= point + point_t'(1);
                end
            end else begin
                step  <= '0;
                point <= '0;
            end

            if (state == st_output && !out_last) begin
                out_idx <= out_idx + 5'd1;
            end else begin
                out_idx <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/search_addr_gen.sv
// search window address generator
`timescale 1ns/10ps
`default_nettype none

module search_addr_gen (
    input  logic               clk,
    input  logic               in_valid2,
    input  mvdm_pkg::pixel_t   in_data,
    input  logic [1:0]         mv_idx,
    input  mvdm_pkg::step_t    step,
    input  mvdm_pkg::point_t   point,
    output mvdm_pkg::coord_t   l0_row,
    output mvdm_pkg::coord_t   l0_col,
    output mvdm_pkg::coord_t   l1_row,
    output mvdm_pkg::coord_t   l1_col
);
    import mvdm_pkg::*;

    // x0, y0, x1, y1
    coord_t     mv [MV_BYTES];
    logic [1:0] dx;
    logic [1:0] dy;
    coord_t     row_ofs;
    coord_t     col_ofs;

    // out of range bytes are held at the edge of the window
    always_ff @(posedge clk) begin
        if (in_valid2) begin
            mv[mv_idx] <= (in_data > pixel_t'(MAX_MV)) ? coord_t'(MAX_MV) : in_data[3:0];
        end
    end

    // point = 3*dx + dy
    always_comb begin
        case (point)
            4'd0:    {dx, dy} = {2'd0, 2'd0};
            4'd1:    {dx, dy} = {2'd0, 2'd1};
            4'd2:    {dx, dy} = {2'd0, 2'd2};
            4'd3:    {dx, dy} = {2'd1, 2'd0};
            4'd4:    {dx, dy} = {2'd1, 2'd1};
            4'd5:    {dx, dy} = {2'd1, 2'd2};
            4'd6:    {dx, dy} = {2'd2, 2'd0};
            4'd7:    {dx, dy} = {2'd2, 2'd1};
            default: {dx, dy} = {2'd2, 2'd2};
        endcase
    end

    // subblock order: top left, top right, bottom left, bottom right
    assign row_ofs = {1'b0, step[3], step[1:0]};
    assign col_ofs = {1'b0, step[2], 2'b00};

    assign l0_row = mv[1] + coord_t'(dy) + row_ofs;
    assign l0_col = mv[0] + coord_t'(dx) + col_ofs;
    // L1 moves the opposite way
    assign l1_row = mv[3] + coord_t'(2'd2 - dy) + row_ofs;
    assign l1_col = mv[2] + coord_t'(2'd2 - dx) + col_ofs;

endmodule

`default_nettype wire

// File: source/frame_buffer.sv
// two image pixel store
`timescale 1ns/10ps
`default_nettype none

module frame_buffer (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               wr_en,
    input  logic [8:0]         wr_addr,
    input  mvdm_pkg::pixel_t   wr_data,
    input  logic               rd_en,
    input  mvdm_pkg::coord_t   l0_row,
    input  mvdm_pkg::coord_t   l0_col,
    input  mvdm_pkg::coord_t   l1_row,
    input  mvdm_pkg::coord_t   l1_col,
    input  mvdm_pkg::step_t    step,
    input  mvdm_pkg::point_t   point,
    output mvdm_pkg::pixel_t   l0_pix [mvdm_pkg::GROUP],
    output mvdm_pkg::pixel_t   l1_pix [mvdm_pkg::GROUP],
    output logic               rd_valid,
    output logic [1:0]         row_idx,
    output logic               block_last,
    output mvdm_pkg::point_t   rd_point
);
    import mvdm_pkg::*;

    // L0 in the lower half, L1 in the upper half
    pixel_t mem [2 * IMG_PIXELS];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        if (rd_en) begin
            for (int k = 0; k < GROUP; k++) begin
                l0_pix[k] <= mem[{1'b0, l0_row, l0_col + coord_t'(k)}];
                l1_pix[k] <= mem[{1'b1, l1_row, l1_col + coord_t'(k)}];
            end
        end
        // tags follow the data
        row_idx    <= step[1:0];
        block_last <= (step == step_t'(STEPS_PER_POINT - 1));
        rd_point   <= point;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
        end
    end

endmodule

`default_nettype wire

// File: source/residual_transform.sv
// residual and row hadamard
`timescale 1ns/10ps
`default_nettype none

module residual_transform (
    input  logic               clk,
    input  logic               rst_n,
    input  mvdm_pkg::pixel_t   l0_pix [mvdm_pkg::GROUP],
    input  mvdm_pkg::pixel_t   l1_pix [mvdm_pkg::GROUP],
    input  logic               in_valid,
    input  logic [1:0]         row_idx,
    input  logic               block_last,
    input  mvdm_pkg::point_t   point,
    output mvdm_pkg::coef_t    row_coef [mvdm_pkg::GROUP],
    output logic               out_valid,
    output logic [1:0]         out_row_idx,
    output logic               out_block_last,
    output mvdm_pkg::point_t   out_point
);
    import mvdm_pkg::*;

    residual_t res [GROUP];
    coef_t     ext [GROUP];

    // L0 - L1, range -255..255
    always_comb begin
        for (int k = 0; k < GROUP; k++) begin
            res[k] = $signed({1'b0, l0_pix[k]}) - $signed({1'b0, l1_pix[k]});
            ext[k] = coef_t'(res[k]);
        end
    end

    // ==============================
    // 4-point hadamard along the row
    // ==============================
    always_ff @(posedge clk) begin
        row_coef[0]    <= ext[0] + ext[1] + ext[2] + ext[3];
        row_coef[1]    <= ext[0] - ext[1] + ext[2] - ext[3];
        row_coef[2]    <= ext[0] + ext[1] - ext[2] - ext[3];
        row_coef[3]    <= ext[0] - ext[1] - ext[2] + ext[3];
        out_row_idx    <= row_idx;
        out_block_last <= block_last;
        out_point      <= point;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

endmodule

`default_nettype wire

// File: source/satd_select.sv
// column hadamard and minimum search
`timescale 1ns/10ps
`default_nettype none

module satd_select (
    input  logic                  clk,
    input  logic                  rst_n,
    input  mvdm_pkg::ctrl_state_e state,
    input  mvdm_pkg::coef_t       row_coef [mvdm_pkg::GROUP],
    input  logic                  in_valid,
    input  logic [1:0]            row_idx,
    input  logic                  block_last,
    input  mvdm_pkg::point_t      point,
    output mvdm_pkg::satd_t       best_satd,
    output mvdm_pkg::point_t      best_point,
    output logic                  search_done
);
    import mvdm_pkg::*;

    coef_t  row_buf [3][GROUP];
    had_t   col_in [4][GROUP];
    had_t   had [4][GROUP];
    had_t   mag;
    satd_t  blk_sum;
    satd_t  acc;
    logic   fresh;
    logic   cmp_pending;
    point_t cmp_point;
    logic   last_row;

    assign last_row = in_valid && (row_idx == 2'd3);

    // rows 0..2 wait here for row 3
    always_ff @(posedge clk) begin
        if (in_valid && row_idx != 2'd3) begin
            row_buf[row_idx] <= row_coef;
        end
    end

    always_comb begin
        for (int j = 0; j < GROUP; j++) begin
            col_in[0][j] = had_t'(row_buf[0][j]);
            col_in[1][j] = had_t'(row_buf[1][j]);
            col_in[2][j] = had_t'(row_buf[2][j]);
            col_in[3][j] = had_t'(row_coef[j]);
            had[0][j] = col_in[0][j] + col_in[1][j] + col_in[2][j] + col_in[3][j];
            had[1][j] = col_in[0][j] - col_in[1][j] + col_in[2][j] - col_in[3][j];
            had[2][j] = col_in[0][j] + col_in[1][j] - col_in[2][j] - col_in[3][j];
            had[3][j] = col_in[0][j] - col_in[1][j] - col_in[2][j] + col_in[3][j];
        end
    end

    // sum of absolute coefficients of one subblock
    always_comb begin
        blk_sum = '0;
        mag     = '0;
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < GROUP; j++) begin
                mag     = had[i][j][12] ? -had[i][j] : had[i][j];
                blk_sum = blk_sum + satd_t'(mag);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (last_row) begin
            acc <= (fresh ? '0 : acc) + blk_sum;
        end
        if (in_valid && block_last) begin
            cmp_point <= point;
        end
    end

    // ==============================
    // point total and best so far
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fresh       <= 1'b1;
            cmp_pending <= 1'b0;
            search_done <= 1'b0;
            best_satd   <= SATD_INIT;
            best_point  <= '0;
        end else begin
            cmp_pending <= last_row && block_last;
            search_done <= cmp_pending && (cmp_point == point_t'(NUM_POINTS - 1));
            if (state == st_idle) begin
                fresh      <= 1'b1;
                best_satd  <= SATD_INIT;
                best_point <= '0;
            end else begin
                if (last_row) begin
                    fresh <= block_last;
                end
                // strict compare keeps the earlier point on a tie
                if (cmp_pending && acc < best_satd) begin
                    best_satd  <= acc;
                    best_point <= cmp_point;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: source/result_serializer.sv
// bit serial result output
`timescale 1ns/10ps
`default_nettype none

module result_serializer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  mvdm_pkg::ctrl_state_e state,
    input  logic [4:0]            out_idx,
    input  mvdm_pkg::satd_t       best_satd,
    input  mvdm_pkg::point_t      best_point,
    output logic                  out_valid,
    output logic                  out_sad
);
    import mvdm_pkg::*;

    // satd goes first, lsb first
    logic [RESULT_BITS-1:0] result;

    assign result = {best_point, best_satd};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_sad   <= 1'b0;
        end else if (state == st_output) begin
            out_valid <= 1'b1;
            out_sad   <= result[out_idx];
        end else begin
            out_valid <= 1'b0;
            out_sad   <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: source/mvdm_top.sv
// motion vector refinement top
`timescale 1ns/10ps
`default_nettype none

module mvdm_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    input  logic               in_valid2,
    input  mvdm_pkg::pixel_t   in_data,
    output logic               out_valid,
    output logic               out_sad
);
    import mvdm_pkg::*;

    ctrl_state_e state;
    logic [8:0]  load_addr;
    logic [1:0]  mv_idx;
    step_t       step;
    point_t      point;
    logic        step_valid;
    logic        load_last;
    logic        mv_last;
    logic        search_last;
    logic [4:0]  out_idx;
    logic        out_last;
    coord_t      l0_row;
    coord_t      l0_col;
    coord_t      l1_row;
    coord_t      l1_col;
    pixel_t      l0_pix [GROUP];
    pixel_t      l1_pix [GROUP];
    logic        rd_valid;
    logic [1:0]  rd_row_idx;
    logic        rd_block_last;
    point_t      rd_point;
    coef_t       row_coef [GROUP];
    logic        coef_valid;
    logic [1:0]  coef_row_idx;
    logic        coef_block_last;
    point_t      coef_point;
    satd_t       best_satd;
    point_t      best_point;
    logic        search_done;

    mvdm_ctrl ctrl0 (
        .clk, .rst_n, .in_valid, .in_valid2, .load_last, .mv_last,
        .search_last, .search_done, .out_last, .state
    );

    search_counter cnt0 (
        .clk, .rst_n, .state, .in_valid, .in_valid2, .load_addr, .mv_idx,
        .step, .point, .step_valid, .load_last, .mv_last, .search_last,
        .out_idx, .out_last
    );

    search_addr_gen addr0 (
        .clk, .in_valid2, .in_data, .mv_idx, .step, .point,
        .l0_row, .l0_col, .l1_row, .l1_col
    );

    frame_buffer fb0 (
        .clk, .rst_n, .wr_en(in_valid), .wr_addr(load_addr), .wr_data(in_data),
        .rd_en(step_valid), .l0_row, .l0_col, .l1_row, .l1_col, .step, .point,
        .l0_pix, .l1_pix, .rd_valid, .row_idx(rd_row_idx),
        .block_last(rd_block_last), .rd_point
    );

    residual_transform rt0 (
        .clk, .rst_n, .l0_pix, .l1_pix, .in_valid(rd_valid),
        .row_idx(rd_row_idx), .block_last(rd_block_last), .point(rd_point),
        .row_coef, .out_valid(coef_valid), .out_row_idx(coef_row_idx),
        .out_block_last(coef_block_last), .out_point(coef_point)
    );

    satd_select sel0 (
        .clk, .rst_n, .state, .row_coef, .in_valid(coef_valid),
        .row_idx(coef_row_idx), .block_last(coef_block_last), .point(coef_point),
        .best_satd, .best_point, .search_done
    );

    result_serializer ser0 (
        .clk, .rst_n, .state, .out_idx, .best_satd, .best_point, .out_valid, .out_sad
    );

endmodule

`default_nettype wire

// File: test/mvdm_asserts.sv
// port protocol assertions
`timescale 1ns/10ps
`default_nettype none

module mvdm_asserts (
    input logic clk,
    input logic rst_n,
    input logic in_valid,
    input logic in_valid2,
    input logic out_valid,
    input logic out_sad
);
    import mvdm_pkg::*;

    int         violations = 0;
    logic [5:0] run_len;

    // consecutive out_valid cycles, saturating
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_len <= '0;
        end else if (!out_valid) begin
            run_len <= '0;
        end else if (run_len != '1) begin
            run_len <= run_len + 6'd1;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) !(in_valid && in_valid2))
        else begin
            violations++;
            $error("in_valid and in_valid2 high in the same cycle");
        end

    assert property (@(posedge clk) disable iff (!rst_n) !out_valid |-> !out_sad)
        else begin
            violations++;
            $error("out_sad high while out_valid is low");
        end

    assert property (@(posedge clk) disable iff (!rst_n) run_len <= 6'(RESULT_BITS))
        else begin
            violations++;
            $error("out_valid high for more than 28 cycles in a row");
        end

endmodule

`default_nettype wire

// File: test/mvdm_tb.sv
// refinement engine testbench
`timescale 1ns/10ps
`default_nettype none

module mvdm_tb;
    import mvdm_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int WAIT_LIMIT = 2000;

    logic       clk;
    logic       rst_n;
    logic       in_valid;
    logic       in_valid2;
    logic [7:0] in_data;
    logic       out_valid;
    logic       out_sad;

    // L0 pixels at 0..255 and L1 at 256..511 in raster order
    logic [7:0] img [2 * IMG_PIXELS];

    mvdm_top dut0 (
        .clk, .rst_n, .in_valid, .in_valid2, .in_data, .out_valid, .out_sad
    );

    bind mvdm_top mvdm_asserts asserts0 (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_valid2(in_valid2),
        .out_valid(out_valid), .out_sad(out_sad)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ==============================
    // error reporting
    // ==============================
    task automatic stop_run();
        $display("Some tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic fail_value(input string test, input int expected, input int actual);
        $display("[FAIL] %s: expected %0d, actual %0d", test, expected, actual);
        stop_run();
    endtask

    task automatic fail_text(input string what);
        $display("%s", what);
        stop_run();
    endtask

    // a protocol violation ends the run at once
    always @(posedge clk) begin
        if (dut0.asserts0.violations != 0) begin
            fail_text("a protocol assertion failed on the DUT ports");
        end
    end

    // ==============================
    // reference model
    // ==============================
    // rows ++++, +-+-, ++--, +--+
    function automatic int had_sign(input int i, input int k);
        case (i)
            0:       return 1;
            1:       return (k % 2 == 0) ? 1 : -1;
            2:       return (k < 2) ? 1 : -1;
            default: return (k == 0 || k == 3) ? 1 : -1;
        endcase
    endfunction

    function automatic int point_satd(input int s, input int x0, input int y0,
                                      input int x1, input int y1);
        int dx;
        int dy;
        int r0;
        int c0;
        int r1;
        int c1;
        int coef;
        int total;
        int res [4][4];
        dx    = s / 3;
        dy    = s % 3;
        total = 0;
        for (int sb = 0; sb < 4; sb++) begin
            r0 = y0 + dy + 4 * (sb / 2);
            c0 = x0 + dx + 4 * (sb % 2);
            r1 = y1 + 2 - dy + 4 * (sb / 2);
            c1 = x1 + 2 - dx + 4 * (sb % 2);
            for (int r = 0; r < 4; r++) begin
                for (int k = 0; k < 4; k++) begin
                    res[r][k] = int'(img[(r0 + r) * IMG_DIM + c0 + k]) -
                                int'(img[IMG_PIXELS + (r1 + r) * IMG_DIM + c1 + k]);
                end
            end
            for (int i = 0; i < 4; i++) begin
                for (int j = 0; j < 4; j++) begin
                    coef = 0;
                    for (int r = 0; r < 4; r++) begin
                        for (int k = 0; k < 4; k++) begin
                            coef += had_sign(i, r) * had_sign(j, k) * res[r][k];
                        end
                    end
                    total += (coef < 0) ? -coef : coef;
                end
            end
        end
        return total;
    endfunction

    // first minimum wins
    task automatic model_best(input int x0, input int y0, input int x1, input int y1,
                              output int best_satd, output int best_point);
        int cost;
        best_satd  = point_satd(0, x0, y0, x1, y1);
        best_point = 0;
        for (int s = 1; s < NUM_POINTS; s++) begin
            cost = point_satd(s, x0, y0, x1, y1);
            if (cost < best_satd) begin
                best_satd  = cost;
                best_point = s;
            end
        end
    endtask

    // ==============================
    // bus drivers
    // ==============================
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic load_images(input bit with_gaps);
        int idle;
        for (int a = 0; a < 2 * IMG_PIXELS; a++) begin
            if (with_gaps && $urandom_range(3, 0) == 0) begin
                idle     = $urandom_range(3, 1);
                in_valid = 1'b0;
                repeat (idle) next_cycle();
            end
            in_valid = 1'b1;
            in_data  = img[a];
            next_cycle();
        end
        in_valid = 1'b0;
        in_data  = '0;
    endtask

    task automatic send_vectors(input int x0, input int y0, input int x1, input int y1);
        int mv [4];
        mv = '{x0, y0, x1, y1};
        for (int k = 0; k < MV_BYTES; k++) begin
            in_valid2 = 1'b1;
            in_data   = 8'(mv[k]);
            next_cycle();
        end
        in_valid2 = 1'b0;
        in_data   = '0;
    endtask

    task automatic receive_result(output int satd, output int pt);
        logic [RESULT_BITS-1:0] bits;
        int waited;
        waited = 0;
        while (!out_valid && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        assert (out_valid) else fail_text("timed out waiting for out_valid");
        for (int b = 0; b < RESULT_BITS; b++) begin
            assert (out_valid) else fail_text("out_valid dropped before all 28 result bits");
            bits[b] = out_sad;
            next_cycle();
        end
        assert (!out_valid) else fail_text("out_valid still high after 28 result bits");
        satd = int'(bits[23:0]);
        pt   = int'(bits[27:24]);
    endtask

    task automatic expect_result(input string name, input int exp_satd, input int exp_point);
        int satd;
        int pt;
        receive_result(satd, pt);
        assert (satd == exp_satd) else fail_value({name, " satd"}, exp_satd, satd);
        assert (pt == exp_point) else fail_value({name, " point"}, exp_point, pt);
    endtask

    // ==============================
    // directed tests
    // ==============================
    task automatic reset_quiet();
        for (int c = 0; c < 40; c++) begin
            assert (out_valid == 1'b0) else fail_value("reset out_valid", 0, out_valid);
            assert (out_sad == 1'b0) else fail_value("reset out_sad", 0, out_sad);
            next_cycle();
        end
    endtask

    // flat residual leaves only the dc term of 16*|a-b| per subblock
    task automatic constant_images();
        int a;
        int b;
        int diff;
        a = $urandom_range(255, 0);
        b = $urandom_range(255, 0);
        for (int p = 0; p < 2 * IMG_PIXELS; p++) begin
            img[p] = (p < IMG_PIXELS) ? 8'(a) : 8'(b);
        end
        load_images(1'b0);
        send_vectors(3, 2, 5, 1);
        diff = (a > b) ? a - b : b - a;
        expect_result("constant", 64 * diff, 0);
    endtask

    task automatic identical_images();
        int x;
        int y;
        for (int p = 0; p < IMG_PIXELS; p++) begin
            img[p]              = 8'($urandom_range(255, 0));
            img[p + IMG_PIXELS] = img[p];
        end
        x = $urandom_range(MAX_MV, 0);
        y = $urandom_range(MAX_MV, 0);
        load_images(1'b0);
        send_vectors(x, y, x, y);
        expect_result("identical", 0, 4);
    endtask

    task automatic random_search();
        int mv [4];
        int exp_satd;
        int exp_point;
        for (int n = 0; n < 3; n++) begin
            for (int p = 0; p < 2 * IMG_PIXELS; p++) begin
                img[p] = 8'($urandom_range(255, 0));
            end
            for (int k = 0; k < 4; k++) begin
                mv[k] = $urandom_range(MAX_MV, 0);
            end
            load_images(1'b1);
            send_vectors(mv[0], mv[1], mv[2], mv[3]);
            model_best(mv[0], mv[1], mv[2], mv[3], exp_satd, exp_point);
            expect_result("random", exp_satd, exp_point);
        end
    endtask

    // second set reuses the stored images
    task automatic repeated_vectors();
        int mv [4];
        int exp_satd;
        int exp_point;
        for (int p = 0; p < 2 * IMG_PIXELS; p++) begin
            img[p] = 8'($urandom_range(255, 0));
        end
        load_images(1'b0);
        for (int n = 0; n < 2; n++) begin
            for (int k = 0; k < 4; k++) begin
                mv[k] = $urandom_range(MAX_MV, 0);
            end
            send_vectors(mv[0], mv[1], mv[2], mv[3]);
            model_best(mv[0], mv[1], mv[2], mv[3], exp_satd, exp_point);
            expect_result("back_to_back", exp_satd, exp_point);
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_valid2 = 1'b0;
        in_data   = '0;
        void'($urandom(50));
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        reset_quiet();
        constant_images();
        identical_images();
        random_search();
        repeated_vectors();

        if (dut0.asserts0.violations == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            fail_text("a protocol assertion failed on the DUT ports");
        end
    end

endmodule

`default_nettype wire

// File: tb.f
source/mvdm_pkg.sv
source/mvdm_ctrl.sv
source/search_counter.sv
source/search_addr_gen.sv
source/frame_buffer.sv
source/residual_transform.sv
source/satd_select.sv
source/result_serializer.sv
source/mvdm_top.sv
test/mvdm_asserts.sv
test/mvdm_tb.sv

// File: Bender.yml
package:
  name: mvdm

sources:
  - files:
      - source/mvdm_pkg.sv
      - source/mvdm_ctrl.sv
      - source/search_counter.sv
      - source/search_addr_gen.sv
      - source/frame_buffer.sv
      - source/residual_transform.sv
      - source/satd_select.sv
      - source/result_serializer.sv
      - source/mvdm_top.sv
  - target: test
    files:
      - test/mvdm_asserts.sv
      - test/mvdm_tb.sv
